//--- source/pid_pkg.sv
package pid_pkg;

   // Width of ADC and DAC words and of every setting
   localparam int SMP_W = 14;

   localparam int N_CH  = 2;  // Input and output channels
   localparam int N_BLK = 4;  // Block index is output * 2 + input

   typedef logic signed [SMP_W-1:0] smp_t;

   // Settings of one PID block
   typedef struct packed {
      smp_t sp;  // Set point
      smp_t kp;  // Proportional gain
      smp_t ki;  // Integral gain
      smp_t kd;  // Derivative gain
   } pid_cfg_t;

   // Bits 1:0 select the field, bits 3:2 the block
   // Bit 4 selects the control register holding the integrator-reset levels
   typedef logic [4:0] cfg_addr_t;

   localparam logic [1:0] FLD_SP = 2'd0;
   localparam logic [1:0] FLD_KP = 2'd1;
   localparam logic [1:0] FLD_KI = 2'd2;
   localparam logic [1:0] FLD_KD = 2'd3;

   // Saturation limits of a sample
   localparam smp_t SMP_MAX = smp_t'(8191);
   localparam smp_t SMP_MIN = smp_t'(-8192);

endpackage

//--- source/pid_cfg_regs.sv
module pid_cfg_regs (
   input  logic                                   clk_i,
   input  logic                                   rstn_i,
   input  logic                                   cfg_we_i,
   input  pid_pkg::cfg_addr_t                     cfg_addr_i,
   input  pid_pkg::smp_t                          cfg_wdata_i,
   output pid_pkg::pid_cfg_t [pid_pkg::N_BLK-1:0] cfg_o,
   output logic              [pid_pkg::N_BLK-1:0] int_rst_o
);
   import pid_pkg::*;

   pid_cfg_t [N_BLK-1:0] cfg_q;
   logic     [N_BLK-1:0] int_rst_q;

   logic                 ctrl_sel;
   logic [1:0]           blk_sel;
   logic [1:0]           fld_sel;

   // Address decode
   assign ctrl_sel = cfg_addr_i[4];
   assign blk_sel  = cfg_addr_i[3:2];
   assign fld_sel  = cfg_addr_i[1:0];

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         cfg_q     <= '0;
         int_rst_q <= '0;
      end else if (cfg_we_i) begin
         if (ctrl_sel) begin
            int_rst_q <= cfg_wdata_i[N_BLK-1:0];  // One level per block
         end else begin
            case (fld_sel)
               FLD_SP:  cfg_q[blk_sel].sp <= cfg_wdata_i;
               FLD_KP:  cfg_q[blk_sel].kp <= cfg_wdata_i;
               FLD_KI:  cfg_q[blk_sel].ki <= cfg_wdata_i;
               FLD_KD:  cfg_q[blk_sel].kd <= cfg_wdata_i;
            endcase
         end
      end
   end

   assign cfg_o     = cfg_q;
   assign int_rst_o = int_rst_q;

   // The control register has a single address and any other low-bit code is undefined
   a_ctrl_addr: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      (cfg_we_i && ctrl_sel) |-> (cfg_addr_i[3:0] == 4'd0)
   ) else $error("control register write to undefined address %0h", cfg_addr_i);

endmodule

//--- source/pid_block.sv
module pid_block #(
   parameter int PSR = 12,
   parameter int ISR = 18,
   parameter int DSR = 10
) (
   input  logic              clk_i,
   input  logic              rstn_i,
   input  pid_pkg::smp_t     dat_i,
   input  pid_pkg::pid_cfg_t cfg_i,
   input  logic              int_rst_i,
   output pid_pkg::smp_t     dat_o
);
   import pid_pkg::*;

   localparam int ERR_W = SMP_W + 1;    // Set point minus sample
   localparam int MUL_W = ERR_W + SMP_W;
   localparam int INT_W = 32;

   localparam logic signed [INT_W-1:0] INT_MAX = {1'b0, {(INT_W-1){1'b1}}};
   localparam logic signed [INT_W-1:0] INT_MIN = {1'b1, {(INT_W-1){1'b0}}};

   logic signed [ERR_W-1:0] err_q;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         err_q <= '0;
      end else begin
         err_q <= cfg_i.sp - dat_i;
      end
   end

   // Proportional path
   logic signed [MUL_W-1:0]     kp_mult;
   logic signed [MUL_W-PSR-1:0] kp_q;

   assign kp_mult = err_q * cfg_i.kp;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         kp_q <= '0;
      end else begin
         kp_q <= kp_mult[MUL_W-1:PSR];
      end
   end

   // Integral path, the product is registered before it is accumulated
   logic signed [MUL_W-1:0]     ki_q;
   logic signed [INT_W:0]       int_sum;
   logic signed [INT_W-1:0]     int_q;
   logic signed [INT_W-ISR-1:0] int_shr;

   assign int_sum = ki_q + int_q;
   assign int_shr = int_q[INT_W-1:ISR];

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         ki_q  <= '0;
         int_q <= '0;
      end else begin
         ki_q <= err_q * cfg_i.ki;
         if (int_rst_i) begin
            int_q <= '0;
         end else if (int_sum[INT_W:INT_W-1] == 2'b01) begin
            int_q <= INT_MAX;   // Positive overflow
         end else if (int_sum[INT_W:INT_W-1] == 2'b10) begin
            int_q <= INT_MIN;   // Negative overflow
         end else begin
            int_q <= int_sum[INT_W-1:0];
         end
      end
   end

   // Derivative path
   logic signed [MUL_W-1:0]   kd_mult;
   logic signed [MUL_W-DSR-1:0] kd_q;
   logic signed [MUL_W-DSR-1:0] kd_prev_q;
   logic signed [MUL_W-DSR:0]   kd_diff_q;

   assign kd_mult = err_q * cfg_i.kd;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         kd_q      <= '0;
         kd_prev_q <= '0;
         kd_diff_q <= '0;
      end else begin
         kd_q      <= kd_mult[MUL_W-1:DSR];
         kd_prev_q <= kd_q;
         kd_diff_q <= kd_q - kd_prev_q;  // Nonzero for one cycle after a step
      end
   end

   // Sum of the three terms, clipped to the sample range
   logic signed [INT_W:0] pid_sum;
   smp_t                  pid_q;

   assign pid_sum = kp_q + int_shr + kd_diff_q;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         pid_q <= '0;
      end else if (pid_sum > SMP_MAX) begin
         pid_q <= SMP_MAX;
      end else if (pid_sum < SMP_MIN) begin
         pid_q <= SMP_MIN;
      end else begin
         pid_q <= pid_sum[SMP_W-1:0];
      end
   end

   assign dat_o = pid_q;

   // The integrator follows the sign of the product and never wraps around its limits
   a_int_up: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      (!int_rst_i && !ki_q[MUL_W-1]) |=> (int_q >= $past(int_q))
   ) else $error("integrator wrapped below its previous value");

   a_int_dn: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      (!int_rst_i && ki_q[MUL_W-1]) |=> (int_q <= $past(int_q))
   ) else $error("integrator wrapped above its previous value");

endmodule

//--- source/pid_out_mix.sv
module pid_out_mix (
   input  logic                                clk_i,
   input  logic                                rstn_i,
   input  pid_pkg::smp_t [pid_pkg::N_BLK-1:0]  blk_dat_i,
   output pid_pkg::smp_t [pid_pkg::N_CH-1:0]   dat_o
);
   import pid_pkg::*;

   localparam int SUM_W = SMP_W + 1;  // One extra bit holds any sum of two samples

   function automatic smp_t sat_add(input smp_t a, input smp_t b);
      logic signed [SUM_W-1:0] sum;
      sum = SUM_W'(a) + SUM_W'(b);
      if (sum > SMP_MAX) begin
         return SMP_MAX;
      end else if (sum < SMP_MIN) begin
         return SMP_MIN;
      end else begin
         return sum[SMP_W-1:0];
      end
   endfunction

   // Output c takes the blocks of all inputs assigned to it
   for (genvar c = 0; c < N_CH; c++) begin : g_ch
      smp_t dat_q;

      always_ff @(posedge clk_i) begin
         if (!rstn_i) begin
            dat_q <= '0;
         end else begin
            dat_q <= sat_add(blk_dat_i[c*N_CH], blk_dat_i[c*N_CH+1]);
         end
      end

      assign dat_o[c] = dat_q;

      a_mix: assert property (
         @(posedge clk_i) disable iff (!rstn_i)
         $past(rstn_i) |->
            (dat_q == sat_add($past(blk_dat_i[c*N_CH]), $past(blk_dat_i[c*N_CH+1])))
      ) else $error("channel %0d output differs from clipped sum", c);
   end

endmodule

//--- source/pid_matrix.sv
module pid_matrix #(
   parameter int PSR = 12,
   parameter int ISR = 18,
   parameter int DSR = 10
) (
   input  logic                               clk_i,
   input  logic                               rstn_i,
   input  pid_pkg::smp_t [pid_pkg::N_CH-1:0]  dat_i,
   input  logic                               cfg_we_i,
   input  pid_pkg::cfg_addr_t                 cfg_addr_i,
   input  pid_pkg::smp_t                      cfg_wdata_i,
   output pid_pkg::smp_t [pid_pkg::N_CH-1:0]  dat_o
);
   import pid_pkg::*;

   pid_cfg_t [N_BLK-1:0] cfg;
   logic     [N_BLK-1:0] int_rst;
   smp_t     [N_BLK-1:0] blk_dat;

   pid_cfg_regs i_cfg_regs (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_o       (cfg),
      .int_rst_o   (int_rst)
   );

   // Block k reads input k mod N_CH and feeds output k / N_CH
   for (genvar k = 0; k < N_BLK; k++) begin : g_blk
      pid_block #(
         .PSR (PSR),
         .ISR (ISR),
         .DSR (DSR)
      ) i_pid_block (
         .clk_i     (clk_i),
         .rstn_i    (rstn_i),
         .dat_i     (dat_i[k % N_CH]),
         .cfg_i     (cfg[k]),
         .int_rst_i (int_rst[k]),
         .dat_o     (blk_dat[k])
      );
   end

   pid_out_mix i_out_mix (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .blk_dat_i (blk_dat),
      .dat_o     (dat_o)
   );

endmodule

//--- verif/pid_tests.svh
`ifndef PID_TESTS_SVH
`define PID_TESTS_SVH

task automatic drive_inputs(input smp_t d0, input smp_t d1);
   dat_in[0] = d0;
   dat_in[1] = d1;
endtask

// Zero every gain and set point and empty all integrators
task automatic clear_config();
   set_int_rst(4'hf);
   for (int k = 0; k < N_BLK; k++) begin
      blk_write(k, FLD_SP, '0);
      blk_write(k, FLD_KP, '0);
      blk_write(k, FLD_KI, '0);
      blk_write(k, FLD_KD, '0);
   end
   wait_cycles(3);
   set_int_rst(4'h0);
   wait_cycles(SETTLE);
endtask

task automatic test_reset();
   for (int i = 0; i < SETTLE; i++) begin
      drive_inputs(smp_t'($random(seed)), smp_t'($random(seed)));
      @(negedge clk);
      compare_smp("dat_o[0]", '0, dat_out[0]);
      compare_smp("dat_o[1]", '0, dat_out[1]);
   end
endtask

task automatic test_p_routing();
   smp_t sp_tab [N_BLK];
   smp_t kp_tab [N_BLK];
   smp_t blk_exp [N_BLK];
   smp_t exp_out;
   sp_tab = '{smp_t'(1200), smp_t'(-800), smp_t'(3000), smp_t'(-2500)};
   kp_tab = '{smp_t'(1500), smp_t'(-2200), smp_t'(700), smp_t'(4000)};
   clear_config();
   for (int k = 0; k < N_BLK; k++) begin
      blk_write(k, FLD_SP, sp_tab[k]);
      blk_write(k, FLD_KP, kp_tab[k]);
   end
   for (int i = 0; i < 6; i++) begin
      drive_inputs(smp_t'($random(seed)), smp_t'($random(seed)));
      wait_cycles(SETTLE);
      for (int k = 0; k < N_BLK; k++) begin
         blk_exp[k] = sat14(p_term(sp_tab[k], dat_in[k % N_CH], kp_tab[k]));
      end
      for (int c = 0; c < N_CH; c++) begin
         exp_out = mix_sum(blk_exp[c*N_CH], blk_exp[c*N_CH+1]);
         compare_smp($sformatf("dat_o[%0d]", c), exp_out, dat_out[c]);
      end
   end
endtask

// Follows an integrating output to its limit, it may only move towards the target
task automatic ramp_to(input int ch, input smp_t target, input bit rising, input int limit);
   smp_t prev;
   int   n;
   prev = dat_out[ch];
   n    = 0;
   while (dat_out[ch] !== target) begin
      if (n >= limit) begin
         report_error($sformatf("Timeout waiting for dat_o[%0d] to reach %0d", ch, target));
      end
      @(negedge clk);
      if (rising ? (dat_out[ch] < prev) : (dat_out[ch] > prev)) begin
         report_error($sformatf("Integrating output dat_o[%0d] moved the wrong way", ch));
      end
      prev = dat_out[ch];
      n++;
   end
endtask

task automatic test_integrator();
   clear_config();
   drive_inputs('0, '0);
   set_int_rst(4'b0001);  // Integrator held empty while block 0 is set up
   blk_write(0, FLD_SP, smp_t'(4000));
   blk_write(0, FLD_KI, smp_t'(8000));
   wait_cycles(SETTLE);
   set_int_rst(4'b0000);
   ramp_to(0, SMP_MAX, 1'b1, 200);
   hold_value(0, SMP_MAX, 20);

   set_int_rst(4'b0001);
   wait_value(0, '0, 20);
   hold_value(0, '0, 20);

   blk_write(0, FLD_SP, smp_t'(-4000));  // Negative error
   wait_cycles(SETTLE);
   set_int_rst(4'b0000);
   ramp_to(0, SMP_MIN, 1'b0, 200);
   hold_value(0, SMP_MIN, 20);
endtask

task automatic derivative_step(input smp_t sp, input smp_t kd, input smp_t old_dat,
                               input smp_t new_dat);
   smp_t exp_pulse;
   smp_t seen;
   int   hits;
   exp_pulse = sat14(shifted_product(sp, new_dat, kd, DSR) -
                     shifted_product(sp, old_dat, kd, DSR));
   hits = 0;
   drive_inputs('0, new_dat);
   for (int i = 0; i < SETTLE; i++) begin
      @(negedge clk);
      seen = dat_out[0];
      if (seen !== '0) begin
         compare_smp("dat_o[0]", exp_pulse, seen);
         hits++;
      end
   end
   if (hits != 1) begin
      report_error($sformatf("Derivative pulse lasted %0d cycles instead of one", hits));
   end
endtask

task automatic test_derivative();
   clear_config();
   drive_inputs('0, smp_t'(100));
   blk_write(1, FLD_KD, smp_t'(2000));
   wait_cycles(SETTLE);
   hold_value(0, '0, 3);
   derivative_step('0, smp_t'(2000), smp_t'(100), smp_t'(-1500));
   derivative_step('0, smp_t'(2000), smp_t'(-1500), smp_t'(8000));  // Pulse clips
endtask

task automatic set_p_pair(input smp_t sp2, input smp_t sp3, input smp_t kp,
                          input smp_t d0, input smp_t d1);
   blk_write(2, FLD_SP, sp2);
   blk_write(3, FLD_SP, sp3);
   blk_write(2, FLD_KP, kp);
   blk_write(3, FLD_KP, kp);
   drive_inputs(d0, d1);
   wait_cycles(SETTLE);
endtask

task automatic test_mix_clip();
   clear_config();
   set_p_pair(smp_t'(8000), smp_t'(8000), smp_t'(8191), smp_t'(-8000), smp_t'(-8000));
   compare_smp("dat_o[1]", SMP_MAX, dat_out[1]);
   set_p_pair(smp_t'(-8000), smp_t'(-8000), smp_t'(8191), smp_t'(8000), smp_t'(8000));
   compare_smp("dat_o[1]", SMP_MIN, dat_out[1]);
   // Gain 4096 cancels the shift, so the P terms equal the errors
   set_p_pair(smp_t'(5000), smp_t'(-3000), smp_t'(4096), '0, '0);
   compare_smp("dat_o[1]", smp_t'(2000), dat_out[1]);
endtask

`endif

//--- verif/pid_tb.sv
module pid_tb;
   import pid_pkg::*;

   localparam int PSR    = 12;
   localparam int ISR    = 18;
   localparam int DSR    = 10;
   localparam int SETTLE = 10;  // Cycles after which a constant input gives a settled output

   logic            clk = 1'b0;
   logic            rstn;
   smp_t [N_CH-1:0] dat_in;
   logic            cfg_we;
   cfg_addr_t       cfg_addr;
   smp_t            cfg_wdata;
   smp_t [N_CH-1:0] dat_out;
   integer          seed;

   always #5 clk = ~clk;

   pid_matrix #(
      .PSR (PSR),
      .ISR (ISR),
      .DSR (DSR)
   ) i_pid_matrix (
      .clk_i       (clk),
      .rstn_i      (rstn),
      .dat_i       (dat_in),
      .cfg_we_i    (cfg_we),
      .cfg_addr_i  (cfg_addr),
      .cfg_wdata_i (cfg_wdata),
      .dat_o       (dat_out)
   );

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_error(input string msg);
      $display("%s at time %0t", msg, $time);
      abort_run();
   endtask

   task automatic compare_smp(input string name, input smp_t expected, input smp_t actual);
      if (actual !== expected) begin
         $display("FAIL time %0t %s expected %0d actual %0d", $time, name, expected, actual);
         abort_run();
      end
   endtask

   // All driving tasks start and end right after a falling edge
   task automatic cfg_write(input cfg_addr_t addr, input smp_t data);
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(negedge clk);
      cfg_we    = 1'b0;
   endtask

   task automatic blk_write(input int blk, input logic [1:0] fld, input smp_t data);
      cfg_write({1'b0, blk[1:0], fld}, data);
   endtask

   task automatic set_int_rst(input logic [N_BLK-1:0] bits);
      cfg_write(5'h10, smp_t'(bits));  // Control register
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_value(input int ch, input smp_t value, input int limit);
      int n;
      n = 0;
      while (dat_out[ch] !== value) begin
         if (n >= limit) begin
            report_error($sformatf("Timeout waiting for dat_o[%0d] to reach %0d", ch, value));
         end
         @(negedge clk);
         n++;
      end
   endtask

   task automatic hold_value(input int ch, input smp_t value, input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         compare_smp($sformatf("dat_o[%0d]", ch), value, dat_out[ch]);
      end
   endtask

   // Reference model of the datapath
   function automatic longint shifted_product(smp_t sp, smp_t dat, smp_t gain, int shift);
      longint err;
      err = longint'(sp) - longint'(dat);
      return (err * longint'(gain)) >>> shift;
   endfunction

   function automatic longint p_term(smp_t sp, smp_t dat, smp_t kp);
      return shifted_product(sp, dat, kp, PSR);
   endfunction

   function automatic smp_t sat14(longint v);
      if (v > 8191) begin
         return smp_t'(8191);
      end else if (v < -8192) begin
         return smp_t'(-8192);
      end
      return smp_t'(v);
   endfunction

   function automatic smp_t mix_sum(smp_t a, smp_t b);
      return sat14(longint'(a) + longint'(b));
   endfunction

   `include "pid_tests.svh"

   initial begin
      seed      = 32'hfce6_a7c2;
      rstn      = 1'b0;
      cfg_we    = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      dat_in[0] = smp_t'($random(seed));
      dat_in[1] = smp_t'($random(seed));
      repeat (8) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;

      test_reset();
      test_p_routing();
      test_integrator();
      test_derivative();
      test_mix_clip();

      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- tb.f
+incdir+verif
source/pid_pkg.sv
source/pid_cfg_regs.sv
source/pid_block.sv
source/pid_out_mix.sv
source/pid_matrix.sv
verif/pid_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the PID matrix testbench with Verilator, runs it and looks for the pass line
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module pid_tb -f tb.f; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vpid_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qF "=== PASS ===" <<< "$sim_out"; then
   exit 0
else
   echo "Pass line not found in simulation output"
   exit 1
fi
